// ==== common/interpPkg.sv ====
`default_nettype none

package interpPkg;

    // --------------------
    // widths
    // --------------------
    localparam int SAMPLE_W = 18;   // input and output samples, signed.
    localparam int CIC_W    = 48;   // integrators wrap at this width.
    localparam int BUS_W    = 32;
    localparam int ADDR_W   = 12;
    localparam int EXP_W    = 5;

    // --------------------
    // register map
    // --------------------
    typedef enum logic [ADDR_W-1:0] {
        REG_CONTROL    = 12'h000,
        REG_TEST_VALUE = 12'h004,
        REG_EXPONENT   = 12'h008,
        REG_MANTISSA   = 12'h00C
    } regAddrE;

    // control register layout.
    localparam int CTRL_W          = 2;
    localparam int CTRL_BYPASS_BIT = 0;
    localparam int CTRL_TEST_BIT   = 1;

    // test has priority over bypass when both control bits are set.
    typedef enum logic [1:0] {
        MODE_FILTER,
        MODE_BYPASS,
        MODE_TEST
    } outModeE;

    // the product is taken from bit 16 up, so 2^16 is a gain of one.
    localparam logic [SAMPLE_W-1:0] MANTISSA_RESET = 18'h10000;

endpackage

`default_nettype wire

// ==== common/interpCtrlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// Settings that only change on bus writes, so they are plain levels.
interface interpCtrlIf;
    import interpPkg::*;

    outModeE             outMode;
    logic [SAMPLE_W-1:0] testValue;
    logic [EXP_W-1:0]    exponent;   // arithmetic right shift of the CIC result.
    logic [SAMPLE_W-1:0] mantissa;   // unsigned gain.

    modport regs (
        output outMode,
        output testValue,
        output exponent,
        output mantissa
    );

    modport stage (
        input outMode,
        input testValue,
        input exponent,
        input mantissa
    );

endinterface

`default_nettype wire

// ==== interpRegs/interpRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module interpRegs (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          clkEn,
    input  wire                          cs,
    input  wire                          wr0,
    input  wire                          wr1,
    input  wire                          wr2,
    input  wire                          wr3,
    input  wire  [interpPkg::ADDR_W-1:0] addr,
    input  wire  [interpPkg::BUS_W-1:0]  din,
    output logic [interpPkg::BUS_W-1:0]  dout,
    output logic                         cicClear,
    interpCtrlIf.regs                    ctrl
);
    import interpPkg::*;

    logic [CTRL_W-1:0]   control;
    logic [SAMPLE_W-1:0] testValue;
    logic [EXP_W-1:0]    exponent;
    logic [SAMPLE_W-1:0] mantissa;
    logic [3:0]          byteWr;
    logic                bypassNew;   // bypass as seen on the latest strobe.
    logic                bypassOld;

    assign byteWr = {wr3, wr2, wr1, wr0};

    // Replaces each byte lane of cur whose strobe is set.
    function automatic logic [BUS_W-1:0] mergeBytes(
        input logic [BUS_W-1:0] cur,
        input logic [BUS_W-1:0] wdata,
        input logic [3:0]       lanes
    );
        logic [BUS_W-1:0] merged;
        merged = cur;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // --------------------
    // bus writes
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            control   <= '0;
            testValue <= '0;
            exponent  <= '0;
            mantissa  <= MANTISSA_RESET;
        end else if (cs) begin
            case (addr)
                REG_CONTROL:    control   <= CTRL_W'(mergeBytes(BUS_W'(control), din, byteWr));
                REG_TEST_VALUE: testValue <= SAMPLE_W'(mergeBytes(BUS_W'(testValue), din, byteWr));
                REG_EXPONENT:   exponent  <= EXP_W'(mergeBytes(BUS_W'(exponent), din, byteWr));
                REG_MANTISSA:   mantissa  <= SAMPLE_W'(mergeBytes(BUS_W'(mantissa), din, byteWr));
                default:        ;   // unmapped words ignore writes.
            endcase
        end
    end

    // readback is combinational and zero when not selected.
    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                REG_CONTROL:    dout = BUS_W'(control);
                REG_TEST_VALUE: dout = BUS_W'(testValue);
                REG_EXPONENT:   dout = BUS_W'(exponent);
                REG_MANTISSA:   dout = BUS_W'(mantissa);
                default:        dout = '0;
            endcase
        end
    end

    assign ctrl.outMode   = control[CTRL_TEST_BIT]   ? MODE_TEST   :
                            control[CTRL_BYPASS_BIT] ? MODE_BYPASS : MODE_FILTER;
    assign ctrl.testValue = testValue;
    assign ctrl.exponent  = exponent;
    assign ctrl.mantissa  = mantissa;

    // --------------------
    // leaving bypass
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bypassNew <= 1'b0;
            bypassOld <= 1'b0;
        end else if (clkEn) begin
            bypassNew <= control[CTRL_BYPASS_BIT];
            bypassOld <= bypassNew;
        end
    end

    // Fires on the strobe after the 1 to 0 step was captured, for exactly one clock.
    assign cicClear = clkEn & bypassOld & ~bypassNew;

endmodule

`default_nettype wire

// ==== source/cicInterpolator.sv ====
`timescale 1ns/10ps
`default_nettype none

module cicInterpolator #(
    parameter int RATE   = 8,
    parameter int STAGES = 3
) (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire                            clkEn,
    input  wire                            cicClear,
    input  wire  [interpPkg::SAMPLE_W-1:0] dataIn,
    output logic [interpPkg::CIC_W-1:0]    cicOut
);
    import interpPkg::*;

    localparam int PHASE_W = (RATE > 1) ? $clog2(RATE) : 1;

    logic [PHASE_W-1:0] phase;
    logic               sampleStrobe;          // clkEn on phase 0, the input rate.
    logic [CIC_W-1:0]   combData  [STAGES+1];  // entry 0 is the widened input.
    logic [CIC_W-1:0]   combDelay [STAGES];
    logic [CIC_W-1:0]   integ     [STAGES];
    logic [CIC_W-1:0]   integFeed;

    assign sampleStrobe = clkEn && (phase == '0);

    // --------------------
    // phase counter
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else if (cicClear) begin
            phase <= '0;
        end else if (clkEn) begin
            if (phase == PHASE_W'(RATE - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // --------------------
    // comb chain
    // --------------------
    assign combData[0] = {{(CIC_W - SAMPLE_W){dataIn[SAMPLE_W-1]}}, dataIn};

    // Each comb is a first difference against the previous accepted sample.
    for (genvar s = 0; s < STAGES; s++) begin : gComb
        assign combData[s+1] = combData[s] - combDelay[s];

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                combDelay[s] <= '0;
            end else if (cicClear) begin
                combDelay[s] <= '0;
            end else if (sampleStrobe) begin
                combDelay[s] <= combData[s];
            end
        end
    end

    // zero stuffing between accepted samples.
    assign integFeed = sampleStrobe ? combData[STAGES] : '0;

    // --------------------
    // integrator chain
    // --------------------
    for (genvar s = 0; s < STAGES; s++) begin : gInteg
        logic [CIC_W-1:0] stageIn;

        if (s == 0) begin : gFirst
            assign stageIn = integFeed;
        end else begin : gNext
            assign stageIn = integ[s-1];   // registered value of the previous sum.
        end

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                integ[s] <= '0;
            end else if (cicClear) begin
                integ[s] <= '0;
            end else if (clkEn) begin
                integ[s] <= integ[s] + stageIn;   // wraps at CIC_W.
            end
        end
    end

    assign cicOut = integ[STAGES-1];

endmodule

`default_nettype wire

// ==== source/interpOutputStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module interpOutputStage (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire                            clkEn,
    input  wire                            cicClear,
    input  wire  [interpPkg::SAMPLE_W-1:0] dataIn,
    input  wire  [interpPkg::CIC_W-1:0]    cicOut,
    output logic [interpPkg::SAMPLE_W-1:0] dataOut,
    interpCtrlIf.stage                     ctrl
);
    import interpPkg::*;

    // signed sample times the mantissa widened to 19 signed bits.
    localparam int PROD_W    = 2 * SAMPLE_W + 1;
    localparam int SLICE_LSB = 16;

    logic signed [CIC_W-1:0]  shifted;
    logic [SAMPLE_W-1:0]      satValue;
    logic [SAMPLE_W-1:0]      shiftReg;
    logic signed [PROD_W-1:0] product;
    logic [SAMPLE_W-1:0]      prodReg;

    // --------------------
    // shift and saturate
    // --------------------
    assign shifted = $signed(cicOut) >>> ctrl.exponent;

    // In range only when every bit above the sample sign bit matches bit 47.
    always_comb begin
        if (!shifted[CIC_W-1] && (|shifted[CIC_W-2:SAMPLE_W-1])) begin
            satValue = {1'b0, {(SAMPLE_W-1){1'b1}}};
        end else if (shifted[CIC_W-1] && !(&shifted[CIC_W-2:SAMPLE_W-1])) begin
            satValue = {1'b1, {(SAMPLE_W-1){1'b0}}};
        end else begin
            satValue = shifted[SAMPLE_W-1:0];
        end
    end

    // --------------------
    // gain
    // --------------------
    assign product = $signed(shiftReg) * $signed({1'b0, ctrl.mantissa});

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '0;
            prodReg  <= '0;
        end else if (cicClear) begin
            shiftReg <= '0;
            prodReg  <= '0;
        end else if (clkEn) begin
            shiftReg <= satValue;
            prodReg  <= product[SLICE_LSB +: SAMPLE_W];   // bits 33 down to 16.
        end
    end

    // --------------------
    // output select
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dataOut <= '0;
        end else begin
            case (ctrl.outMode)
                MODE_TEST: begin
                    dataOut <= ctrl.testValue;   // follows the register without clkEn.
                end
                MODE_BYPASS: begin
                    if (clkEn) begin
                        dataOut <= dataIn;
                    end
                end
                default: begin
                    if (clkEn) begin
                        dataOut <= prodReg;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/interpolatorTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module interpolatorTop #(
    parameter int RATE   = 8,
    parameter int STAGES = 3
) (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire                            clkEn,
    input  wire                            cs,
    input  wire                            wr0,
    input  wire                            wr1,
    input  wire                            wr2,
    input  wire                            wr3,
    input  wire  [interpPkg::ADDR_W-1:0]   addr,
    input  wire  [interpPkg::BUS_W-1:0]    din,
    output logic [interpPkg::BUS_W-1:0]    dout,
    input  wire  [interpPkg::SAMPLE_W-1:0] dataIn,
    output logic [interpPkg::SAMPLE_W-1:0] dataOut
);
    import interpPkg::*;

    logic             cicClear;
    logic [CIC_W-1:0] cicOut;

    interpCtrlIf ctrlBus ();

    interpRegs regs (
        .clk      (clk),
        .rstN     (rstN),
        .clkEn    (clkEn),
        .cs       (cs),
        .wr0      (wr0),
        .wr1      (wr1),
        .wr2      (wr2),
        .wr3      (wr3),
        .addr     (addr),
        .din      (din),
        .dout     (dout),
        .cicClear (cicClear),
        .ctrl     (ctrlBus.regs)
    );

    cicInterpolator #(
        .RATE   (RATE),
        .STAGES (STAGES)
    ) cic (
        .clk      (clk),
        .rstN     (rstN),
        .clkEn    (clkEn),
        .cicClear (cicClear),
        .dataIn   (dataIn),
        .cicOut   (cicOut)
    );

    interpOutputStage outStage (
        .clk      (clk),
        .rstN     (rstN),
        .clkEn    (clkEn),
        .cicClear (cicClear),
        .dataIn   (dataIn),
        .cicOut   (cicOut),
        .dataOut  (dataOut),
        .ctrl     (ctrlBus.stage)
    );

endmodule

`default_nettype wire

// ==== dv/interpModel.svh ====
`ifndef INTERP_MODEL_SVH
`define INTERP_MODEL_SVH

// Cycle model of the interpolator. It is advanced once per rising edge with
// the inputs that the DUT sees at that edge.

logic [1:0]          mControl;
logic [SAMPLE_W-1:0] mTestValue;
logic [EXP_W-1:0]    mExponent;
logic [SAMPLE_W-1:0] mMantissa;
logic                mBypSeen;       // bypass as sampled on the latest strobe.
logic                mBypPrev;
int                  mPhase;
logic [CIC_W-1:0]    mComb [STAGES];
logic [CIC_W-1:0]    mInteg [STAGES];
logic [SAMPLE_W-1:0] mShift;
logic [SAMPLE_W-1:0] mProd;
logic [SAMPLE_W-1:0] mOut;

task automatic resetModel();
    mControl   = '0;
    mTestValue = '0;
    mExponent  = '0;
    mMantissa  = MANTISSA_RESET;
    mBypSeen   = 1'b0;
    mBypPrev   = 1'b0;
    mPhase     = 0;
    for (int s = 0; s < STAGES; s++) begin
        mComb[s]  = '0;
        mInteg[s] = '0;
    end
    mShift = '0;
    mProd  = '0;
    mOut   = '0;
endtask

function automatic logic [BUS_W-1:0] expectedReadback(input logic sel,
                                                      input logic [ADDR_W-1:0] a);
    if (!sel) begin
        return '0;
    end
    case (a)
        REG_CONTROL:    return BUS_W'(mControl);
        REG_TEST_VALUE: return BUS_W'(mTestValue);
        REG_EXPONENT:   return BUS_W'(mExponent);
        REG_MANTISSA:   return BUS_W'(mMantissa);
        default:        return '0;
    endcase
endfunction

// arithmetic shift, then clamp to the signed sample range.
function automatic logic [SAMPLE_W-1:0] shiftSaturate(input logic [CIC_W-1:0] v,
                                                      input logic [EXP_W-1:0] e);
    logic signed [CIC_W-1:0] s;
    s = $signed(v) >>> e;
    if (s > 48'sd131071) begin
        return 18'h1ffff;
    end
    if (s < -48'sd131072) begin
        return 18'h20000;
    end
    return s[SAMPLE_W-1:0];
endfunction

function automatic logic [SAMPLE_W-1:0] applyGain(input logic [SAMPLE_W-1:0] x,
                                                  input logic [SAMPLE_W-1:0] m);
    longint xs;
    longint ms;
    longint p;
    xs = longint'($signed(x));
    ms = longint'(m);   // the mantissa is unsigned.
    p  = xs * ms;
    return p[33:16];
endfunction

task automatic advanceModel(input logic en, input logic sel, input logic [3:0] lanes,
                            input logic [ADDR_W-1:0] a, input logic [BUS_W-1:0] wdata,
                            input logic [SAMPLE_W-1:0] sample);
    logic                clear;
    logic [CIC_W-1:0]    x;
    logic [CIC_W-1:0]    diff;
    logic [CIC_W-1:0]    feed;
    logic [SAMPLE_W-1:0] nextShift;
    logic [SAMPLE_W-1:0] nextProd;
    logic [BUS_W-1:0]    word;
    clear     = en && mBypPrev && !mBypSeen;
    nextShift = shiftSaturate(mInteg[STAGES-1], mExponent);
    nextProd  = applyGain(mShift, mMantissa);
    if (mControl[1]) begin
        mOut = mTestValue;
    end else if (en) begin
        mOut = mControl[0] ? sample : mProd;
    end
    if (clear) begin
        resetFilter();
    end else if (en) begin
        feed = '0;
        if (mPhase == 0) begin
            x = {{(CIC_W - SAMPLE_W){sample[SAMPLE_W-1]}}, sample};
            for (int s = 0; s < STAGES; s++) begin
                diff     = x - mComb[s];
                mComb[s] = x;
                x        = diff;
            end
            feed = x;   // zero on the stuffed strobes.
        end
        for (int s = STAGES - 1; s > 0; s--) begin
            mInteg[s] = mInteg[s] + mInteg[s-1];
        end
        mInteg[0] = mInteg[0] + feed;
        mPhase    = (mPhase + 1) % RATE;
        mShift    = nextShift;
        mProd     = nextProd;
    end
    if (en) begin
        mBypPrev = mBypSeen;
        mBypSeen = mControl[0];
    end
    if (sel) begin
        word = expectedReadback(1'b1, a);
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                word[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        case (a)
            REG_CONTROL:    mControl   = word[1:0];
            REG_TEST_VALUE: mTestValue = word[SAMPLE_W-1:0];
            REG_EXPONENT:   mExponent  = word[EXP_W-1:0];
            REG_MANTISSA:   mMantissa  = word[SAMPLE_W-1:0];
            default:        ;
        endcase
    end
endtask

task automatic resetFilter();
    mPhase = 0;
    for (int s = 0; s < STAGES; s++) begin
        mComb[s]  = '0;
        mInteg[s] = '0;
    end
    mShift = '0;
    mProd  = '0;
endtask

`endif

// ==== dv/interpTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module interpTb;
    import interpPkg::*;

    localparam int          RATE   = 8;
    localparam int          STAGES = 3;
    localparam logic [31:0] SEED   = 32'hea6b;

    logic                clk;
    logic                rstN;
    logic                clkEn;
    logic                cs;
    logic                wr0;
    logic                wr1;
    logic                wr2;
    logic                wr3;
    logic [ADDR_W-1:0]   addr;
    logic [BUS_W-1:0]    din;
    logic [BUS_W-1:0]    dout;
    logic [SAMPLE_W-1:0] dataIn;
    logic [SAMPLE_W-1:0] dataOut;

    int                  sampleAmp;     // 0 selects the full sample range.
    int                  enPercent;
    int                  strobeCount;
    logic                pendCs;
    logic [3:0]          pendLanes;
    logic [ADDR_W-1:0]   pendAddr;
    logic [BUS_W-1:0]    pendData;

    `include "interpModel.svh"

    interpolatorTop #(
        .RATE   (RATE),
        .STAGES (STAGES)
    ) UUT (
        .clk     (clk),
        .rstN    (rstN),
        .clkEn   (clkEn),
        .cs      (cs),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .addr    (addr),
        .din     (din),
        .dout    (dout),
        .dataIn  (dataIn),
        .dataOut (dataOut)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch on %s at %0t: expected 0x%0h, got 0x%0h",
                     name, $time, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "first error");
        end
    endtask

    function automatic logic [SAMPLE_W-1:0] randomSample(input int amp);
        int v;
        if (amp == 0) begin
            return SAMPLE_W'($urandom);
        end
        v = int'($urandom % (2 * amp + 1)) - amp;
        return SAMPLE_W'(v);
    endfunction

    // --------------------
    // clocking the DUT
    // --------------------
    // the model takes the inputs of this edge before new ones are driven.
    task automatic stepClock();
        @(posedge clk);
        if (clkEn) begin
            strobeCount++;
        end
        advanceModel(clkEn, cs, {wr3, wr2, wr1, wr0}, addr, din, dataIn);
        clkEn  <= (($urandom % 100) < enPercent);
        dataIn <= randomSample(sampleAmp);
        cs     <= pendCs;
        addr   <= pendAddr;
        din    <= pendData;
        {wr3, wr2, wr1, wr0} <= pendLanes;
        @(negedge clk);
        checkValue("dataOut", 64'(mOut), 64'(dataOut));
        checkValue("dout", 64'(expectedReadback(cs, addr)), 64'(dout));
    endtask

    task automatic runCycles(input int n);
        repeat (n) stepClock();
    endtask

    task automatic runStrobes(input int n);
        int target;
        int waited;
        target = strobeCount + n;
        waited = 0;
        while (strobeCount < target) begin
            if (waited > 20 * n + 50) begin
                $display("Timeout while waiting for %0d clkEn strobes", n);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout");
            end
            stepClock();
            waited++;
        end
    endtask

    // one clock with cs high; no lanes set makes it a read.
    task automatic busAccess(input logic [ADDR_W-1:0] a, input logic [BUS_W-1:0] d,
                             input logic [3:0] lanes);
        pendCs    = 1'b1;
        pendAddr  = a;
        pendData  = d;
        pendLanes = lanes;
        stepClock();
        pendCs    = 1'b0;
        pendLanes = '0;
    endtask

    task automatic writeReg(input logic [ADDR_W-1:0] a, input logic [BUS_W-1:0] d);
        busAccess(a, d, 4'hf);
    endtask

    task automatic randomAccess();
        logic [ADDR_W-1:0] a;
        case ($urandom % 5)
            0:       a = REG_CONTROL;
            1:       a = REG_TEST_VALUE;
            2:       a = REG_EXPONENT;
            3:       a = REG_MANTISSA;
            default: a = ADDR_W'($urandom);
        endcase
        busAccess(a, $urandom, 4'($urandom));
        busAccess(a, $urandom, 4'h0);
    endtask

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rstN        = 1'b0;
        clkEn       = 1'b0;
        cs          = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        addr        = '0;
        din         = '0;
        dataIn      = '0;
        pendCs      = 1'b0;
        pendLanes   = '0;
        pendAddr    = '0;
        pendData    = '0;
        sampleAmp   = 1000;
        enPercent   = 50;
        strobeCount = 0;
        resetModel();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // register map, including unmapped words.
        for (int i = 0; i < 80; i++) begin
            randomAccess();
        end

        writeReg(REG_CONTROL, 32'h0);
        writeReg(REG_EXPONENT, 32'h0);
        writeReg(REG_MANTISSA, 32'h10000);
        runStrobes(400);   // unity gain, small samples stay in range.

        // gain path with full-scale samples that saturate.
        sampleAmp = 0;
        for (int i = 0; i < 12; i++) begin
            writeReg(REG_EXPONENT, $urandom % 32);
            writeReg(REG_MANTISSA, $urandom % 32'h40000);
            runStrobes(60);
        end

        writeReg(REG_CONTROL, 32'h1);
        runStrobes(100);

        // test value wins over bypass and needs no strobe.
        writeReg(REG_TEST_VALUE, $urandom);
        writeReg(REG_CONTROL, 32'h2);
        runStrobes(30);
        enPercent = 0;
        runCycles(10);
        writeReg(REG_TEST_VALUE, $urandom);
        runCycles(5);
        writeReg(REG_CONTROL, 32'h3);
        writeReg(REG_TEST_VALUE, $urandom);
        runCycles(10);
        enPercent = 50;
        runStrobes(20);

        // filter must restart from a clean state after bypass.
        sampleAmp = 1000;
        writeReg(REG_EXPONENT, 32'h0);
        writeReg(REG_MANTISSA, 32'h10000);
        writeReg(REG_CONTROL, 32'h1);
        runStrobes(40);
        writeReg(REG_CONTROL, 32'h0);
        runStrobes(200);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
common/interpPkg.sv
common/interpCtrlIf.sv
interpRegs/interpRegs.sv
source/cicInterpolator.sv
source/interpOutputStage.sv
source/interpolatorTop.sv
dv/interpTb.sv

// ==== Makefile ====
# Verilator build and run for the interpolator testbench.

VERILATOR ?= verilator
TOP       ?= interpTb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) dv/interpModel.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, so the exit status of the binary is ignored here.
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
